/* test/cbus_tests.txt */
# op order word_addr
# op is W (write) or R (read), beats = 2**order, word_addr in hex
W 0 00
R 0 00
W 2 10
R 2 10
W 1 20
W 1 22
W 2 24
R 3 20
W 3 40
R 3 40
R 2 44
W 0 05
W 2 41
R 3 40
R 0 05
W 3 f8
R 3 f8
R 1 fc
W 2 12
R 2 12
W 3 80
R 0 87
R 2 84
R 3 80

/* src.f */
design/cbus_axi_pkg.sv
design/burst_counter.sv
design/cbus_axi_fsm.sv
design/axi_sram.sv
design/cbus_axi_top.sv
test/clock_gen.sv
test/cbus_axi_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := cbus_axi_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/cbus_axi_tb.sv */
`default_nettype none

module cbus_axi_tb;
    localparam logic [31:0] LFSR_SEED       = 32'h7f57;
    localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;
    localparam int          CYCLES_PER_TEST = 64;
    localparam int          MAX_BEATS       = 1 << cbus_axi_pkg::CBUS_LEN_BITS;

    logic                     clk;
    logic                     reset;
    cbus_axi_pkg::cbus_req_t  cbus_req;
    cbus_axi_pkg::cbus_resp_t cbus_resp;

    // reference copy of the backing memory
    cbus_axi_pkg::data_t model [cbus_axi_pkg::MEM_WORDS];
    cbus_axi_pkg::data_t wbuf [MAX_BEATS];

    logic [7:0]  test_op [$];
    int          test_order [$];
    int          test_word [$];
    logic [31:0] lfsr;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    cbus_axi_top dut (
        .clk       (clk),
        .reset     (reset),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

    // run limit, set once the test file is loaded
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // one Galois step per bit taken
    function automatic cbus_axi_pkg::data_t random_word();
        cbus_axi_pkg::data_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    task automatic load_tests();
        int         fd;
        int         n;
        string      line;
        logic [7:0] op;
        int         order;
        int         word;
        fd = $fopen("test/cbus_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open test/cbus_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%c %d %h", op, order, word);
            if (n != 3 || (op != "W" && op != "R") || order < 0
                || order > cbus_axi_pkg::CBUS_LEN_BITS) begin
                $display("malformed test line: %s", line);
                errors++;
            end else begin
                test_op.push_back(op);
                test_order.push_back(order);
                test_word.push_back(word);
            end
        end
        $fclose(fd);
    endtask

    // one cache-bus request, held until the beat with last
    task automatic run_request(input logic is_write, input int order, input int word);
        int  beats;
        int  okays;
        int  idx;
        logic done;
        beats = 1 << order;
        if (is_write) begin
            for (int i = 0; i < beats; i++) begin
                wbuf[i] = random_word();
            end
        end
        @(negedge clk);
        cbus_req.valid    = 1'b1;
        cbus_req.is_write = is_write;
        cbus_req.addr     = cbus_axi_pkg::addr_t'(word) << 2;
        cbus_req.order    = cbus_axi_pkg::order_t'(order);
        cbus_req.wdata    = is_write ? wbuf[0] : '0;
        okays = 0;
        done  = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (cbus_resp.okay) begin
                idx = (word + okays) % cbus_axi_pkg::MEM_WORDS;
                checks++;
                if (okays >= beats) begin
                    $display("FAILED at %0t: okay number %0d on a %0d beat request",
                             $time, okays + 1, beats);
                    errors++;
                end else if (is_write) begin
                    model[idx] = wbuf[okays];
                end else if (cbus_resp.rdata !== model[idx]) begin
                    $display("FAILED at %0t: read word %0h got %h expected %h",
                             $time, idx, cbus_resp.rdata, model[idx]);
                    errors++;
                end
                if (cbus_resp.last) begin
                    done = 1'b1;
                    if (okays != beats - 1) begin
                        $display("FAILED at %0t: last on okay %0d of %0d",
                                 $time, okays + 1, beats);
                        errors++;
                    end
                end else if (okays == beats - 1) begin
                    $display("FAILED at %0t: final okay of %0d came without last", $time, beats);
                    errors++;
                end
                okays++;
            end else if (cbus_resp.last) begin
                $display("FAILED at %0t: last raised without okay", $time);
                errors++;
                done = 1'b1;
            end
            if (!done) begin
                @(negedge clk);
                // next beat's data once the previous beat is done
                if (is_write && okays < beats) begin
                    cbus_req.wdata = wbuf[okays];
                end
            end
        end
    endtask

    initial begin
        cbus_req = '0;
        lfsr     = LFSR_SEED;
        for (int i = 0; i < cbus_axi_pkg::MEM_WORDS; i++) begin
            model[i] = '0;
        end
        load_tests();
        cycle_limit = test_op.size() * CYCLES_PER_TEST + 100;
        @(posedge clk);
        while (reset) @(posedge clk);
        // requests follow each other without idle cycles
        for (int t = 0; t < test_op.size(); t++) begin
            run_request(test_op[t] == "W", test_order[t], test_word[t]);
        end
        @(negedge clk);
        cbus_req = '0;
        repeat (4) @(posedge clk);
        $display("requests: %0d, beat checks: %0d, errors: %0d", test_op.size(), checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/clock_gen.sv */
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);
    // period of 100 time units
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset covers the first 8 rising edges and drops on a falling edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* design/cbus_axi_top.sv */
`default_nettype none

module cbus_axi_top (
    input  logic                     clk,
    input  logic                     reset,
    input  cbus_axi_pkg::cbus_req_t  cbus_req,
    output cbus_axi_pkg::cbus_resp_t cbus_resp
);
    // AXI link between bridge and memory
    cbus_axi_pkg::axi_req_t  axi_req;
    cbus_axi_pkg::axi_resp_t axi_resp;

    cbus_axi_fsm u_bridge (
        .clk       (clk),
        .reset     (reset),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp),
        .axi_req   (axi_req),
        .axi_resp  (axi_resp)
    );

    // backing memory, stalls every address phase by one cycle
    axi_sram u_sram (
        .clk      (clk),
        .reset    (reset),
        .axi_req  (axi_req),
        .axi_resp (axi_resp)
    );

endmodule

`default_nettype wire

/* design/axi_sram.sv */
`default_nettype none

module axi_sram (
    input  logic                    clk,
    input  logic                    reset,
    input  cbus_axi_pkg::axi_req_t  axi_req,
    output cbus_axi_pkg::axi_resp_t axi_resp
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE,
        S_RESP
    } state_t;

    state_t                 state;
    logic                   stalled;
    cbus_axi_pkg::mem_idx_t index;
    cbus_axi_pkg::axi_len_t beat_cnt;
    cbus_axi_pkg::data_t    mem [cbus_axi_pkg::MEM_WORDS];

    // an address is taken only once it has been held valid for a cycle
    // AR wins if both arrive together
    always_comb begin
        axi_resp.ar_ready = (state == S_IDLE) && stalled && axi_req.ar.valid;
        axi_resp.aw_ready = (state == S_IDLE) && stalled && axi_req.aw.valid
                         && !axi_req.ar.valid;
        axi_resp.w_ready  = (state == S_WRITE);
        axi_resp.r.valid  = (state == S_READ);
        axi_resp.r.data   = mem[index];
        axi_resp.r.last   = (beat_cnt == '0);
        axi_resp.b.valid  = (state == S_RESP);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            stalled  <= 1'b0;
            index    <= '0;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (axi_resp.ar_ready) begin
                        state    <= S_READ;
                        stalled  <= 1'b0;
                        index    <= axi_req.ar.addr[cbus_axi_pkg::MEM_IDX_BITS+1:2];
                        beat_cnt <= axi_req.ar.len;
                    end else if (axi_resp.aw_ready) begin
                        state    <= S_WRITE;
                        stalled  <= 1'b0;
                        index    <= axi_req.aw.addr[cbus_axi_pkg::MEM_IDX_BITS+1:2];
                        beat_cnt <= axi_req.aw.len;
                    end else begin
                        stalled <= axi_req.ar.valid || axi_req.aw.valid;
                    end
                end
                S_READ: if (axi_req.r_ready) begin
                    if (beat_cnt == '0) begin
                        state <= S_IDLE;
                    end else begin
                        index    <= index + 1'b1;
                        beat_cnt <= beat_cnt - 1'b1;
                    end
                end
                S_WRITE: if (axi_req.w.valid) begin
                    index    <= index + 1'b1;
                    beat_cnt <= beat_cnt - 1'b1;
                    if (axi_req.w.last) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: if (axi_req.b_ready) begin
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // byte lanes follow the write strobe
    always_ff @(posedge clk) begin
        if ((state == S_WRITE) && axi_req.w.valid) begin
            for (int i = 0; i < $bits(cbus_axi_pkg::strb_t); i++) begin
                if (axi_req.w.strb[i]) begin
                    mem[index][8*i +: 8] <= axi_req.w.data[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/cbus_axi_fsm.sv */
`default_nettype none

module cbus_axi_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  cbus_axi_pkg::cbus_req_t  cbus_req,
    output cbus_axi_pkg::cbus_resp_t cbus_resp,
    output cbus_axi_pkg::axi_req_t   axi_req,
    input  cbus_axi_pkg::axi_resp_t  axi_resp
);
    typedef enum logic [1:0] {
        IDLE,
        TRANSFER,
        REQUEST,
        WAITING
    } state_t;

    state_t                  state;
    cbus_axi_pkg::addr_t     current_addr;
    cbus_axi_pkg::addr_t     addr_step;
    cbus_axi_pkg::axi_len_t  burst_len;
    cbus_axi_pkg::axi_addr_t addr_beat;
    logic                    is_last;
    logic                    is_final;
    logic                    load;
    logic                    next_round;
    logic                    step;
    logic                    addr_ok;
    logic                    rw_handshake;
    logic                    transaction_ok;

    burst_counter u_counter (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .next_round (next_round),
        .step       (step),
        .order      (cbus_req.order),
        .burst_len  (burst_len),
        .is_last    (is_last),
        .is_final   (is_final)
    );

    // one round moves burst_len + 1 words of 4 bytes
    assign addr_step = (cbus_axi_pkg::addr_t'(burst_len) + 32'd1) << 2;

    assign addr_ok = (axi_req.ar.valid && axi_resp.ar_ready)
                  || (axi_req.aw.valid && axi_resp.aw_ready);
    assign rw_handshake = (axi_req.w.valid && axi_resp.w_ready)
                       || (axi_req.r_ready && axi_resp.r.valid);
    assign transaction_ok = axi_req.b_ready && axi_resp.b.valid;

    // counter steering
    assign load = (state == IDLE) && cbus_req.valid;
    assign step = (state == TRANSFER) && rw_handshake && !is_last;
    assign next_round = ((state == TRANSFER) && rw_handshake && is_last && !is_final
                         && !cbus_req.is_write)
                     || ((state == WAITING) && transaction_ok && !is_final);

    // the okay of a round's last write beat waits for the B response
    always_comb begin
        cbus_resp.rdata = axi_resp.r.data;
        cbus_resp.okay  = (cbus_req.is_write && is_last) ? transaction_ok : rw_handshake;
        cbus_resp.last  = is_final && (cbus_req.is_write ? transaction_ok : rw_handshake);
    end

    always_comb begin
        addr_beat.valid = 1'b1;
        addr_beat.addr  = current_addr;
        addr_beat.len   = burst_len;
        addr_beat.size  = cbus_axi_pkg::AXI_SIZE_WORD;
        addr_beat.burst = cbus_axi_pkg::BURST_INCR;

        axi_req = '0;
        case (state)
            REQUEST: begin
                if (cbus_req.is_write) begin
                    axi_req.aw = addr_beat;
                end else begin
                    axi_req.ar = addr_beat;
                end
            end
            TRANSFER: begin
                if (cbus_req.is_write) begin
                    axi_req.w.valid = 1'b1;
                    axi_req.w.data  = cbus_req.wdata;
                    axi_req.w.strb  = cbus_axi_pkg::AXI_FULL_STROBE;
                    axi_req.w.last  = is_last;
                end else begin
                    axi_req.r_ready = 1'b1;
                end
            end
            WAITING: axi_req.b_ready = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (cbus_req.valid) begin
                    state <= REQUEST;
                end
                REQUEST: if (addr_ok) begin
                    state <= TRANSFER;
                end
                TRANSFER: if (rw_handshake && is_last) begin
                    if (cbus_req.is_write) begin
                        state <= WAITING;
                    end else if (is_final) begin
                        state <= IDLE;
                    end else begin
                        state <= REQUEST;
                    end
                end
                WAITING: if (transaction_ok) begin
                    state <= is_final ? IDLE : REQUEST;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // burst address, latched at the start and advanced after each round
    always_ff @(posedge clk) begin
        if (load) begin
            current_addr <= cbus_req.addr;
        end else if ((state == TRANSFER) && rw_handshake && is_last) begin
            current_addr <= current_addr + addr_step;
        end
    end

endmodule

`default_nettype wire

/* design/burst_counter.sv */
`default_nettype none

module burst_counter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,
    input  logic                   next_round,
    input  logic                   step,
    input  cbus_axi_pkg::order_t   order,
    output cbus_axi_pkg::axi_len_t burst_len,
    output logic                   is_last,
    output logic                   is_final
);
    cbus_axi_pkg::beat_idx_t beats_m1;
    cbus_axi_pkg::axi_len_t  len_init;
    cbus_axi_pkg::round_t    round_init;
    cbus_axi_pkg::axi_len_t  len_cnt;
    cbus_axi_pkg::round_t    round_cnt;

    // beats minus one, upper bits count the rounds and lower bits the beats per round
    assign beats_m1 = cbus_axi_pkg::beat_idx_t'((32'd1 << order) - 32'd1);
    assign {round_init, len_init} = beats_m1;

    always_ff @(posedge clk) begin
        if (reset) begin
            burst_len <= '0;
            len_cnt   <= '0;
            round_cnt <= '0;
        end else if (load) begin
            burst_len <= len_init;
            len_cnt   <= len_init;
            round_cnt <= round_init;
        end else if (next_round) begin
            len_cnt   <= burst_len;
            round_cnt <= round_cnt - 1'b1;
        end else if (step) begin
            len_cnt <= len_cnt - 1'b1;
        end
    end

    assign is_last  = (len_cnt == '0);
    assign is_final = is_last && (round_cnt == '0);

endmodule

`default_nettype wire

/* design/cbus_axi_pkg.sv */
`default_nettype none

package cbus_axi_pkg;

    // beat index over a whole cache-bus burst, and the narrowed AXI len field
    localparam int CBUS_LEN_BITS = 3;
    localparam int AXI_LEN_BITS  = 2;
    localparam int ROUND_BITS    = CBUS_LEN_BITS - AXI_LEN_BITS;

    // backing memory depth in 32-bit words
    localparam int MEM_WORDS    = 256;
    localparam int MEM_IDX_BITS = $clog2(MEM_WORDS);

    typedef logic [31:0]               addr_t;
    typedef logic [31:0]               data_t;
    typedef logic [3:0]                strb_t;
    typedef logic [2:0]                order_t;
    typedef logic [CBUS_LEN_BITS-1:0]  beat_idx_t;
    typedef logic [AXI_LEN_BITS-1:0]   axi_len_t;
    typedef logic [ROUND_BITS-1:0]     round_t;
    typedef logic [2:0]                axi_size_t;
    typedef logic [1:0]                axi_burst_t;
    typedef logic [MEM_IDX_BITS-1:0]   mem_idx_t;

    localparam strb_t      AXI_FULL_STROBE = '1;
    localparam axi_size_t  AXI_SIZE_WORD   = 3'd2;
    localparam axi_burst_t BURST_INCR      = 2'd1;

    // cache bus, request held for the whole transfer
    typedef struct packed {
        logic   valid;
        logic   is_write;
        addr_t  addr;
        order_t order;
        data_t  wdata;
    } cbus_req_t;

    typedef struct packed {
        logic  okay;
        logic  last;
        data_t rdata;
    } cbus_resp_t;

    // AXI channels, no ids and no error responses
    typedef struct packed {
        logic       valid;
        addr_t      addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_addr_t;

    typedef struct packed {
        logic  valid;
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        logic  valid;
        data_t data;
        logic  last;
    } axi_r_t;

    typedef struct packed {
        logic valid;
    } axi_b_t;

    typedef struct packed {
        axi_addr_t ar;
        axi_addr_t aw;
        axi_w_t    w;
        logic      r_ready;
        logic      b_ready;
    } axi_req_t;

    typedef struct packed {
        logic   ar_ready;
        logic   aw_ready;
        logic   w_ready;
        axi_r_t r;
        axi_b_t b;
    } axi_resp_t;

endpackage

`default_nettype wire
